// File: div_cfg.svh
// Divider configuration
// Data width and bit counter setup for the serial radix-2 divider

`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result width
`define DIV_WIDTH 32

// Bit counter holds the dividend bit index
`define DIV_CNT_WIDTH 5
`define DIV_CNT_START 31

`endif

// File: div_pkg.sv
// Divider types
// Word, bit index, operation and sequencing state definitions

`default_nettype none

`include "div_cfg.svh"

package div_pkg;

  typedef logic [`DIV_WIDTH-1:0]     word_t;
  typedef logic [`DIV_CNT_WIDTH-1:0] count_t;

  typedef enum logic [0:0] {
    DIV_OP_DIV,
    DIV_OP_REM
  } div_op_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

endpackage

`default_nettype wire

// File: div_ctrl_if.sv
// Divider control bundle
// Carries state, step position and hold control between FSM, counter and datapath

`timescale 1ns/1ps
`default_nettype none

interface div_ctrl_if;

  div_pkg::div_state_e state;
  logic                step_last;
  div_pkg::count_t     bit_idx;
  logic                divisor_zero;
  // Low only while the result waits for ready
  logic                advance;

  modport fsm (
    output state, advance,
    input  step_last, divisor_zero
  );

  modport cnt (
    input  state, advance,
    output step_last, bit_idx
  );

  modport dp (
    input  state, bit_idx, advance,
    output divisor_zero
  );

endinterface

`default_nettype wire

// File: div_fsm.sv
// Divider sequencing FSM
// Walks absolute value, compare and sign steps and holds the result until ready

`timescale 1ns/1ps
`default_nettype none

module div_fsm (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   start_i,
  input  logic   const_time_i,
  input  logic   ready_i,
  div_ctrl_if.fsm ctrl,
  output logic   valid_o
);

  div_pkg::div_state_e state_q, state_d;
  logic                hold;

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_d = state_q;

    unique case (state_q)
      div_pkg::DIV_IDLE: begin
        if (start_i) begin
          // Zero divisor finishes at once unless timing must not depend on data
          if (ctrl.divisor_zero && !const_time_i) begin
            state_d = div_pkg::DIV_FINISH;
          end else begin
            state_d = div_pkg::DIV_ABS_A;
          end
        end
      end

      div_pkg::DIV_ABS_A: begin
        state_d = div_pkg::DIV_ABS_B;
      end

      div_pkg::DIV_ABS_B: begin
        state_d = div_pkg::DIV_COMP;
      end

      div_pkg::DIV_COMP: begin
        if (ctrl.step_last) begin
          state_d = div_pkg::DIV_LAST;
        end
      end

      div_pkg::DIV_LAST: begin
        state_d = div_pkg::DIV_SIGN;
      end

      div_pkg::DIV_SIGN: begin
        state_d = div_pkg::DIV_FINISH;
      end

      div_pkg::DIV_FINISH: begin
        state_d = div_pkg::DIV_IDLE;
      end

      default: begin
        state_d = div_pkg::DIV_IDLE;
      end
    endcase
  end

  // Result stays put while the consumer is not ready
  assign hold = (state_q == div_pkg::DIV_FINISH) && !ready_i;

  //////////////////////////////
  // State register
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= div_pkg::DIV_IDLE;
    end else if (!hold) begin
      state_q <= state_d;
    end
  end

  assign ctrl.state   = state_q;
  assign ctrl.advance = ~hold;
  assign valid_o      = (state_q == div_pkg::DIV_FINISH);

endmodule

`default_nettype wire

// File: div_bit_counter.sv
// Divider bit counter
// Counts the dividend bit index down during the compare steps

`timescale 1ns/1ps
`default_nettype none

`include "div_cfg.svh"

module div_bit_counter (
  input  logic   clk_i,
  input  logic   rst_ni,
  div_ctrl_if.cnt ctrl
);

  div_pkg::count_t cnt_q, cnt_d;

  // Reload outside the compare phase
  assign cnt_d = (ctrl.state == div_pkg::DIV_COMP) ? cnt_q - 1'b1
                                                    : div_pkg::count_t'(`DIV_CNT_START);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ctrl.advance) begin
      cnt_q <= cnt_d;
    end
  end

  assign ctrl.bit_idx   = cnt_q;
  // Bit one is the last step handled in the compare state
  assign ctrl.step_last = (cnt_q == div_pkg::count_t'(1));

endmodule

`default_nettype wire

// File: div_datapath.sv
// Divider datapath
// Operand capture, magnitudes, restoring compare-subtract and final sign fixup
// One shared subtractor serves every step

`timescale 1ns/1ps
`default_nettype none

`include "div_cfg.svh"

module div_datapath (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  div_pkg::word_t    a_i,
  input  div_pkg::word_t    b_i,
  input  div_pkg::div_op_e  op_i,
  input  logic              signed_i,
  div_ctrl_if.dp            ctrl,
  output div_pkg::word_t    result_o
);

  // Operands, replaced by their magnitudes in the abs steps
  div_pkg::word_t   numer_q;
  div_pkg::word_t   denom_q;
  div_pkg::word_t   rem_q;
  div_pkg::word_t   quot_q;
  div_pkg::div_op_e op_q;
  logic             sign_a_q;
  logic             sign_b_q;
  logic             div_zero_q;

  div_pkg::word_t        sub_a;
  div_pkg::word_t        sub_b;
  logic [`DIV_WIDTH:0]   sub_res;
  div_pkg::word_t        sub_word;
  logic                  ge;
  div_pkg::word_t        next_rem;
  div_pkg::word_t        next_quot;
  div_pkg::count_t       next_bit_idx;
  logic                  negate;

  assign ctrl.divisor_zero = (b_i == '0);

  //////////////////////////////
  // Shared subtractor
  //////////////////////////////
  always_comb begin
    sub_a = '0;
    sub_b = numer_q;

    unique case (ctrl.state)
      div_pkg::DIV_ABS_B: begin
        sub_b = denom_q;
      end
      div_pkg::DIV_COMP,
      div_pkg::DIV_LAST: begin
        sub_a = rem_q;
        sub_b = denom_q;
      end
      div_pkg::DIV_SIGN: begin
        sub_b = rem_q;
      end
      default: begin
        // 0 - |a| in IDLE and ABS_A
        sub_b = numer_q;
      end
    endcase
  end

  // Extra top bit is the borrow, so the compare is unsigned
  assign sub_res  = {1'b0, sub_a} - {1'b0, sub_b};
  assign sub_word = sub_res[`DIV_WIDTH-1:0];
  assign ge       = ~sub_res[`DIV_WIDTH];

  // Restoring step
  assign next_rem     = ge ? sub_word : rem_q;
  assign next_quot    = quot_q | (div_pkg::word_t'(ge) << ctrl.bit_idx);
  assign next_bit_idx = ctrl.bit_idx - 1'b1;

  // Quotient sign follows the operand signs, remainder follows the dividend
  assign negate = (op_q == div_pkg::DIV_OP_DIV) ? ((sign_a_q ^ sign_b_q) & ~div_zero_q)
                                                : sign_a_q;

  //////////////////////////////
  // Registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      numer_q    <= '0;
      denom_q    <= '0;
      rem_q      <= '0;
      quot_q     <= '0;
      op_q       <= div_pkg::DIV_OP_DIV;
      sign_a_q   <= 1'b0;
      sign_b_q   <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (ctrl.advance) begin
      unique case (ctrl.state)
        div_pkg::DIV_IDLE: begin
          numer_q    <= a_i;
          denom_q    <= b_i;
          op_q       <= op_i;
          sign_a_q   <= signed_i & a_i[`DIV_WIDTH-1];
          sign_b_q   <= signed_i & b_i[`DIV_WIDTH-1];
          div_zero_q <= ctrl.divisor_zero;
          // Preset holds the RISC-V divide-by-zero result
          rem_q      <= (op_i == div_pkg::DIV_OP_DIV) ? '1 : a_i;
        end

        div_pkg::DIV_ABS_A: begin
          quot_q <= '0;
          if (sign_a_q) begin
            numer_q <= sub_word;
          end
        end

        div_pkg::DIV_ABS_B: begin
          if (sign_b_q) begin
            denom_q <= sub_word;
          end
          // First partial remainder is the dividend MSB
          rem_q <= {{(`DIV_WIDTH-1){1'b0}}, numer_q[`DIV_WIDTH-1]};
        end

        div_pkg::DIV_COMP: begin
          rem_q  <= {next_rem[`DIV_WIDTH-2:0], numer_q[next_bit_idx]};
          quot_q <= next_quot;
        end

        div_pkg::DIV_LAST: begin
          // Only the requested half is kept from here on
          rem_q <= (op_q == div_pkg::DIV_OP_DIV) ? next_quot : next_rem;
        end

        div_pkg::DIV_SIGN: begin
          if (negate) begin
            rem_q <= sub_word;
          end
        end

        default: begin
          rem_q <= rem_q;
        end
      endcase
    end
  end

  assign result_o = rem_q;

endmodule

`default_nettype wire

// File: serial_divider.sv
// Serial radix-2 integer divider
// 32-bit DIV and REM, signed or unsigned, with RISC-V corner case results

`timescale 1ns/1ps
`default_nettype none

module serial_divider (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  div_pkg::div_op_e op_i,
  input  logic             signed_i,
  input  logic             const_time_i,
  input  div_pkg::word_t   a_i,
  input  div_pkg::word_t   b_i,
  input  logic             ready_i,
  output logic             valid_o,
  output div_pkg::word_t   result_o
);

  div_ctrl_if ctrl ();

  //////////////////////////////
  // Control
  //////////////////////////////
  div_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .const_time_i (const_time_i),
    .ready_i      (ready_i),
    .ctrl         (ctrl.fsm),
    .valid_o      (valid_o)
  );

  div_bit_counter u_bit_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ctrl   (ctrl.cnt)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////
  div_datapath u_datapath (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .a_i      (a_i),
    .b_i      (b_i),
    .op_i     (op_i),
    .signed_i (signed_i),
    .ctrl     (ctrl.dp),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

// File: tb_serial_divider.sv
// Serial divider testbench
// Table cases and LFSR random cases against a RISC-V division model
// Checks latency, back-pressure hold and start pulses while busy

`timescale 1ns/1ps
`default_nettype none

module tb_serial_divider;

  // Rising edges after the accepting edge until valid_o is seen high
  localparam int LAT_FULL = 35;
  localparam int LAT_FAST = 0;
  localparam int TIMEOUT  = 100;
  localparam int N_RANDOM = 40;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        is_rem;
    logic        sgn;
    logic        ct;
    logic [2:0]  delay;
    logic [31:0] exp_res;
  } entry_t;

  logic             clk_i;
  logic             rst_ni;
  logic             start_i;
  div_pkg::div_op_e op_i;
  logic             signed_i;
  logic             const_time_i;
  div_pkg::word_t   a_i;
  div_pkg::word_t   b_i;
  logic             ready_i;
  logic             valid_o;
  div_pkg::word_t   result_o;

  entry_t      table_q[$];
  logic [31:0] lfsr_q;

  serial_divider uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .op_i         (op_i),
    .signed_i     (signed_i),
    .const_time_i (const_time_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .ready_i      (ready_i),
    .valid_o      (valid_o),
    .result_o     (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // Galois form of x^32 + x^22 + x^2 + x + 1
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output div_pkg::word_t v);
    int i;
    begin
      v = '0;
      for (i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v = {v[30:0], lfsr_q[0]};
      end
    end
  endtask

  // RISC-V DIV/DIVU/REM/REMU result
  function automatic div_pkg::word_t ref_result(input div_pkg::word_t a, input div_pkg::word_t b,
                                                input logic is_rem, input logic sgn);
    logic           neg_a;
    logic           neg_b;
    div_pkg::word_t mag_a;
    div_pkg::word_t mag_b;
    div_pkg::word_t q;
    div_pkg::word_t r;
    begin
      if (b == '0) begin
        return is_rem ? a : '1;
      end
      neg_a = sgn & a[31];
      neg_b = sgn & b[31];
      mag_a = neg_a ? -a : a;
      mag_b = neg_b ? -b : b;
      q = mag_a / mag_b;
      r = mag_a % mag_b;
      if (neg_a ^ neg_b) begin
        q = -q;
      end
      if (neg_a) begin
        r = -r;
      end
      return is_rem ? r : q;
    end
  endfunction

  task automatic fail_run();
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input div_pkg::word_t got,
                             input div_pkg::word_t exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      fail_run();
    end
  endtask

  task automatic add_entry(input div_pkg::word_t a, input div_pkg::word_t b, input logic is_rem,
                           input logic sgn, input logic ct, input logic [2:0] delay,
                           input div_pkg::word_t exp_res);
    entry_t e;
    begin
      e.a       = a;
      e.b       = b;
      e.is_rem  = is_rem;
      e.sgn     = sgn;
      e.ct      = ct;
      e.delay   = delay;
      e.exp_res = exp_res;
      table_q.push_back(e);
    end
  endtask

  //////////////////////////////
  // One division with handshake
  //////////////////////////////
  task automatic run_case(input div_pkg::word_t a, input div_pkg::word_t b, input logic is_rem,
                          input logic sgn, input logic ct, input int delay,
                          input div_pkg::word_t exp_res);
    int lat;
    int exp_lat;
    begin
      exp_lat = ((b == '0) && !ct) ? LAT_FAST : LAT_FULL;
      @(posedge clk_i);
      #1;
      a_i          = a;
      b_i          = b;
      op_i         = is_rem ? div_pkg::DIV_OP_REM : div_pkg::DIV_OP_DIV;
      signed_i     = sgn;
      const_time_i = ct;
      ready_i      = 1'b0;
      start_i      = 1'b1;
      // Accepting edge
      @(posedge clk_i);
      #1;
      // Start stays high one more cycle with other operands and must be ignored
      a_i = ~a;
      b_i = b + 32'd3;
      lat = 0;
      @(negedge clk_i);
      while (!valid_o) begin
        if (lat >= TIMEOUT) begin
          $display("Timeout, valid_o never rose within %0d cycles at %0t", TIMEOUT, $time);
          fail_run();
        end
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        lat++;
        @(negedge clk_i);
      end
      check_value("valid_o latency", lat, exp_lat);
      check_value("result_o", result_o, exp_res);

      // Consumer not ready yet
      repeat (delay) begin
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        @(negedge clk_i);
        check_value("valid_o", valid_o, 1);
        check_value("result_o", result_o, exp_res);
      end
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
      ready_i = 1'b1;
      // Handshake edge
      @(posedge clk_i);
      #1;
      ready_i = 1'b0;
      @(negedge clk_i);
      check_value("valid_o", valid_o, 0);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    entry_t         e;
    div_pkg::word_t a;
    div_pkg::word_t b;
    div_pkg::word_t r;
    int             i;

    rst_ni       = 1'b0;
    start_i      = 1'b0;
    op_i         = div_pkg::DIV_OP_DIV;
    signed_i     = 1'b0;
    const_time_i = 1'b0;
    a_i          = '0;
    b_i          = '0;
    ready_i      = 1'b0;
    lfsr_q       = 32'h3699_3d54;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_value("valid_o", valid_o, 0);
    check_value("result_o", result_o, 0);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // a, b, rem, signed, const time, ready delay, expected
    add_entry(32'd100,      32'd7,        1'b0, 1'b0, 1'b0, 3'd0, 32'h0000_000e);
    add_entry(32'd100,      32'd7,        1'b1, 1'b0, 1'b0, 3'd3, 32'h0000_0002);
    add_entry(32'hffff_ffff, 32'd3,       1'b0, 1'b0, 1'b0, 3'd0, 32'h5555_5555);
    add_entry(32'hffff_ffff, 32'd10,      1'b1, 1'b0, 1'b0, 3'd1, 32'h0000_0005);
    add_entry(32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0, 1'b0, 3'd1, 32'h0000_0000);
    // Signed with all four sign pairs
    add_entry(32'd7,        32'd2,        1'b0, 1'b1, 1'b0, 3'd0, 32'h0000_0003);
    add_entry(32'd7,        32'd2,        1'b1, 1'b1, 1'b0, 3'd0, 32'h0000_0001);
    add_entry(32'hffff_fff9, 32'd2,       1'b0, 1'b1, 1'b0, 3'd2, 32'hffff_fffd);
    add_entry(32'hffff_fff9, 32'd2,       1'b1, 1'b1, 1'b0, 3'd0, 32'hffff_ffff);
    add_entry(32'd7,        32'hffff_fffe, 1'b0, 1'b1, 1'b0, 3'd0, 32'hffff_fffd);
    add_entry(32'd7,        32'hffff_fffe, 1'b1, 1'b1, 1'b0, 3'd0, 32'h0000_0001);
    add_entry(32'hffff_fff9, 32'hffff_fffe, 1'b0, 1'b1, 1'b0, 3'd0, 32'h0000_0003);
    add_entry(32'hffff_fff9, 32'hffff_fffe, 1'b1, 1'b1, 1'b0, 3'd4, 32'hffff_ffff);
    // Signed overflow
    add_entry(32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, 1'b0, 3'd0, 32'h8000_0000);
    add_entry(32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 1'b0, 3'd0, 32'h0000_0000);
    // Divide by zero in fast and constant time mode
    add_entry(32'h1234_5678, 32'd0,       1'b0, 1'b0, 1'b0, 3'd0, 32'hffff_ffff);
    add_entry(32'h8765_4321, 32'd0,       1'b1, 1'b1, 1'b0, 3'd2, 32'h8765_4321);
    add_entry(32'h8765_4321, 32'd0,       1'b0, 1'b1, 1'b1, 3'd0, 32'hffff_ffff);
    add_entry(32'hdead_beef, 32'd0,       1'b1, 1'b0, 1'b1, 3'd1, 32'hdead_beef);

    for (i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      run_case(e.a, e.b, e.is_rem, e.sgn, e.ct, e.delay, e.exp_res);
    end

    // Random operands with the divisor often shortened so quotients are not trivial
    for (i = 0; i < N_RANDOM; i++) begin
      take_bits(32, a);
      take_bits(32, b);
      take_bits(8, r);
      if (r[7:5] == 3'd7) begin
        b = '0;
      end else begin
        b = b >> (r[7:5] * 4);
      end
      run_case(a, b, r[0], r[1], r[2], r[4:3], ref_result(a, b, r[0], r[1]));
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
div_pkg.sv
div_ctrl_if.sv
div_fsm.sv
div_bit_counter.sv
div_datapath.sv
serial_divider.sv
tb_serial_divider.sv

// File: Bender.yml
package:
  name: serial_divider

export_include_dirs:
  - .

sources:
  - div_pkg.sv
  - div_ctrl_if.sv
  - div_fsm.sv
  - div_bit_counter.sv
  - div_datapath.sv
  - serial_divider.sv
  - target: test
    files:
      - tb_serial_divider.sv
